//--- include/dataMem_config.svh
`ifndef DATAMEM_CONFIG_SVH
`define DATAMEM_CONFIG_SVH

// byte address seen by the core
`define DM_ADDR_WIDTH 32

// one RV32I word
`define DM_DATA_WIDTH 32

`define DM_DEPTH_WORDS 1024 // word index from addr[11:2]

// bytes per word, one bank each
`define DM_LANES 4

`endif

//--- source/memAccessPkg.sv
`include "dataMem_config.svh"

package memAccessPkg;

	// values are the func3 encodings of the load and store forms
	typedef enum logic [2:0]
	{
		opByte  = 3'd0, // lb and sb
		opHalf  = 3'd1, // lh and sh
		opWord  = 3'd2, // lw and sw
		opByteU = 3'd4, // lbu only
		opHalfU = 3'd5  // lhu only
	} accessOp;

	// one access from the core side, presented every cycle
	typedef struct packed
	{
		logic                      writeEnable; // high for a store
		accessOp                   op;
		logic [`DM_ADDR_WIDTH-1:0] addr;        // byte address
		logic [`DM_DATA_WIDTH-1:0] writeData;   // store data, low aligned
	} memRequest;

endpackage

//--- source/laneBankPkg.sv
`include "dataMem_config.svh"

package laneBankPkg;

	// command for a single byte lane, one per bank
	typedef struct packed
	{
		logic                                writeEnable; // write this lane
		logic [$clog2(`DM_DEPTH_WORDS)-1:0] wordIndex;   // shared by all lanes
		logic [7:0]                          byteData;    // byte already routed to lane
	} laneCommand;

endpackage

//--- source/storeAligner.sv
`timescale 1ns/1ps
`include "dataMem_config.svh"

module storeAligner
(
	input  memAccessPkg::memRequest                req,
	output laneBankPkg::laneCommand [`DM_LANES-1:0] laneCmd,
	output logic                                   misaligned
);

	localparam int indexWidth = $clog2(`DM_DEPTH_WORDS);

	logic [1:0]                offset;
	logic [`DM_LANES-1:0]      laneSel;  // lanes touched by the access
	logic [`DM_LANES-1:0]      laneWe;
	logic [`DM_DATA_WIDTH-1:0] laneData; // store data replicated across lanes
	logic                      storeOk;

	assign offset = req.addr[1:0];

	always_comb
	begin
		misaligned = 1'b0;
		storeOk    = 1'b0;
		laneSel    = '0;
		laneData   = req.writeData;
		case (req.op)
			memAccessPkg::opByte:
			begin
				laneSel  = `DM_LANES'(1) << offset;
				laneData = {`DM_LANES{req.writeData[7:0]}};
				storeOk  = 1'b1; // bytes never cross
			end
			memAccessPkg::opHalf:
			begin
				laneSel  = `DM_LANES'(3) << offset;
				laneData = {(`DM_LANES / 2){req.writeData[15:0]}};
				if (offset[0])
					misaligned = 1'b1;
				else
					storeOk = 1'b1;
			end
			memAccessPkg::opWord:
			begin
				laneSel = {`DM_LANES{1'b1}};
				if (offset != 2'd0)
					misaligned = 1'b1;
				else
					storeOk = 1'b1;
			end
			memAccessPkg::opHalfU:
				misaligned = offset[0]; // lhu faults like lh
			default:; // lbu and unused codes store nothing
		endcase

		laneWe = (req.writeEnable && storeOk) ? laneSel : '0;
	end

	for (genvar i = 0; i < `DM_LANES; i++)
	begin : laneGen
		assign laneCmd[i].writeEnable = laneWe[i];
		assign laneCmd[i].wordIndex   = req.addr[indexWidth + 1:2];
		assign laneCmd[i].byteData    = laneData[8 * i +: 8]; // byte i of the word
	end

	// a faulting access must leave every bank untouched
	always_comb
	begin
		for (int i = 0; i < `DM_LANES; i++)
		begin
			assert (!(misaligned && laneCmd[i].writeEnable))
			else
				$error("storeAligner: lane %0d written during misaligned access", i);
		end
	end

endmodule

//--- source/byteLaneBank.sv
`timescale 1ns/1ps
`include "dataMem_config.svh"

module byteLaneBank
(
	input  logic                                clk,
	input  logic                                rstN,
	input  laneBankPkg::laneCommand             cmd,
	input  logic [$clog2(`DM_DEPTH_WORDS)-1:0] watchIndex,
	output logic [7:0]                          readByte,
	output logic [7:0]                          watchByte
);

	logic [7:0] mem [`DM_DEPTH_WORDS];

	always_ff @(posedge clk)
	begin
		if (cmd.writeEnable)
			mem[cmd.wordIndex] <= cmd.byteData;
	end

	// both ports sample before the write lands, so same-word reads see old data
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			readByte  <= '0;
			watchByte <= '0;
		end
		else
		begin
			readByte  <= mem[cmd.wordIndex];
			watchByte <= mem[watchIndex]; // debugger view
		end
	end

	// an unknown byte written here would poison later loads on this lane
	assert property (@(posedge clk) disable iff (!rstN)
		cmd.writeEnable |-> !$isunknown({cmd.wordIndex, cmd.byteData}))
	else
		$error("byteLaneBank: write with unknown index or data");

endmodule

//--- source/loadExtractor.sv
`timescale 1ns/1ps
`include "dataMem_config.svh"

module loadExtractor
(
	input  logic                      clk,
	input  logic                      rstN,
	input  memAccessPkg::accessOp     op,
	input  logic [1:0]                offset,
	input  logic                      misaligned,
	input  logic [`DM_DATA_WIDTH-1:0] laneBytes,
	output logic [`DM_DATA_WIDTH-1:0] readData,
	output logic                      readFault
);

	memAccessPkg::accessOp     opReg;
	logic [1:0]                offsetReg;
	logic                      faultReg;
	logic [`DM_DATA_WIDTH-1:0] shifted; // addressed byte moved to bit 0

	// line up with the lane bytes the banks register on the same edge
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			opReg     <= memAccessPkg::opByte;
			offsetReg <= '0;
			faultReg  <= 1'b0;
		end
		else
		begin
			opReg     <= op;
			offsetReg <= offset;
			faultReg  <= misaligned;
		end
	end

	assign shifted = laneBytes >> {offsetReg, 3'b000};

	always_comb
	begin
		readData = '0; // faults and unused codes read as zero
		if (!faultReg)
		begin
			case (opReg)
				memAccessPkg::opByte:  readData = {{(`DM_DATA_WIDTH - 8){shifted[7]}}, shifted[7:0]};
				memAccessPkg::opHalf:  readData = {{(`DM_DATA_WIDTH - 16){shifted[15]}}, shifted[15:0]};
				memAccessPkg::opWord:  readData = laneBytes;
				memAccessPkg::opByteU: readData = {{(`DM_DATA_WIDTH - 8){1'b0}}, shifted[7:0]};
				memAccessPkg::opHalfU: readData = {{(`DM_DATA_WIDTH - 16){1'b0}}, shifted[15:0]};
				default:;
			endcase
		end
	end

	assign readFault = faultReg;

	// func3 values 3, 6 and 7 have no load form
	assert property (@(posedge clk) disable iff (!rstN)
		opReg inside {memAccessPkg::opByte, memAccessPkg::opHalf, memAccessPkg::opWord,
			memAccessPkg::opByteU, memAccessPkg::opHalfU})
	else
		$error("loadExtractor: illegal access opcode %0d", opReg);

endmodule

//--- source/dataMem.sv
`timescale 1ns/1ps
`include "dataMem_config.svh"

module dataMem
(
	input  logic                      clk,
	input  logic                      rstN,
	input  memAccessPkg::memRequest   req,
	input  logic [`DM_ADDR_WIDTH-1:0] watchAddr,
	output logic [`DM_DATA_WIDTH-1:0] readData,
	output logic                      readFault,
	output logic [`DM_DATA_WIDTH-1:0] watchData
);

	localparam int indexWidth = $clog2(`DM_DEPTH_WORDS);

	laneBankPkg::laneCommand [`DM_LANES-1:0] laneCmd;
	logic                                    misaligned;
	logic [`DM_LANES-1:0][7:0]               laneRead;  // lane i is byte i
	logic [`DM_LANES-1:0][7:0]               laneWatch;

	storeAligner u_storeAligner
	(
		.req        (req),
		.laneCmd    (laneCmd),
		.misaligned (misaligned)
	);

	for (genvar i = 0; i < `DM_LANES; i++)
	begin : bankGen
		byteLaneBank u_byteLaneBank
		(
			.clk        (clk),
			.rstN       (rstN),
			.cmd        (laneCmd[i]),
			.watchIndex (watchAddr[indexWidth + 1:2]),
			.readByte   (laneRead[i]),
			.watchByte  (laneWatch[i])
		);
	end

	loadExtractor u_loadExtractor
	(
		.clk        (clk),
		.rstN       (rstN),
		.op         (req.op),
		.offset     (req.addr[1:0]),
		.misaligned (misaligned),
		.laneBytes  (laneRead),
		.readData   (readData),
		.readFault  (readFault)
	);

	assign watchData = laneWatch; // lanes packed high to low form the word

endmodule

//--- sim/clockGen.sv
`timescale 1ns/1ps

module clockGen
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

endmodule

//--- sim/dataMemTb.sv
`timescale 1ns/1ps
`include "dataMem_config.svh"

module dataMemTb;

	localparam int randWrites = 24;
	localparam int nameBits   = 8 * 24;

	logic                      clk;
	logic                      rstN;
	memAccessPkg::memRequest   req;
	logic [`DM_ADDR_WIDTH-1:0] watchAddr;
	logic [`DM_DATA_WIDTH-1:0] readData;
	logic                      readFault;
	logic [`DM_DATA_WIDTH-1:0] watchData;

	logic [nameBits-1:0]       vecName [$];
	logic                      vecWr [$];
	logic [2:0]                vecOp [$];
	logic [`DM_ADDR_WIDTH-1:0] vecAddr [$];
	logic [`DM_DATA_WIDTH-1:0] vecWdata [$];
	logic [`DM_DATA_WIDTH-1:0] vecExp [$];
	logic                      vecFault [$];

	logic [`DM_DATA_WIDTH-1:0] refMem [`DM_DEPTH_WORDS]; // model of word contents
	logic [31:0]               lcgState;
	int                        passCount;
	int                        failCount;
	int                        totalCycles;
	bit                        loaded;

	// access issued last cycle, waiting for its result
	bit                        pendValid;
	logic [nameBits-1:0]       pendName;
	logic [`DM_DATA_WIDTH-1:0] pendData;
	logic                      pendFault;
	bit                        pendWatchOn;
	logic [`DM_DATA_WIDTH-1:0] pendWatch;

	clockGen u_clockGen
	(
		.clk (clk)
	);

	dataMem u_dataMem
	(
		.clk       (clk),
		.rstN      (rstN),
		.req       (req),
		.watchAddr (watchAddr),
		.readData  (readData),
		.readFault (readFault),
		.watchData (watchData)
	);

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic checkPending();
		bit ok;
		ok = 1'b1;
		if (pendValid)
		begin
			if (readFault !== pendFault)
			begin
				$display("mismatch %0s fault expected %0d actual %0d", pendName, pendFault, readFault);
				ok = 1'b0;
			end
			if (readData !== pendData)
			begin
				$display("mismatch %0s data expected %h actual %h", pendName, pendData, readData);
				ok = 1'b0;
			end
			if (pendWatchOn && (watchData !== pendWatch))
			begin
				$display("mismatch %0s watch expected %h actual %h", pendName, pendWatch, watchData);
				ok = 1'b0;
			end
			if (ok)
			begin
				passCount++;
				$display("pass %0s", pendName);
			end
			else
				failCount++;
		end
		pendValid = 1'b0;
	endtask

	// results are registered, so they are read back one edge after the drive
	task automatic issue(input logic [nameBits-1:0] name, input logic we, input logic [2:0] op,
		input logic [`DM_ADDR_WIDTH-1:0] addr, input logic [`DM_DATA_WIDTH-1:0] wdata,
		input logic [`DM_DATA_WIDTH-1:0] expData, input logic expFault, input bit watchOn,
		input logic [`DM_DATA_WIDTH-1:0] expWatch);
		@(posedge clk);
		#1;
		checkPending();
		req.writeEnable = we;
		req.op          = memAccessPkg::accessOp'(op);
		req.addr        = addr;
		req.writeData   = wdata;
		watchAddr       = addr; // watch the same word
		pendValid       = 1'b1;
		pendName        = name;
		pendData        = expData;
		pendFault       = expFault;
		pendWatchOn     = watchOn;
		pendWatch       = expWatch;
	endtask

	task automatic drainPipe();
		@(posedge clk);
		#1;
		checkPending();
		req.writeEnable = 1'b0;
		req.op          = memAccessPkg::opWord;
	endtask

	// contents are not reset, so start from known zeros
	task automatic clearMemory();
		for (int i = 0; i < `DM_DEPTH_WORDS; i++)
		begin
			@(posedge clk);
			#1;
			req.writeEnable = 1'b1;
			req.op          = memAccessPkg::opWord;
			req.addr        = `DM_ADDR_WIDTH'(i * 4);
			req.writeData   = '0;
			watchAddr       = '0;
			refMem[i]       = '0;
		end
	endtask

	task automatic loadVectors(input int fd);
		int                        count;
		int                        wr;
		int                        op;
		int                        flt;
		logic [`DM_ADDR_WIDTH-1:0] a;
		logic [`DM_DATA_WIDTH-1:0] w;
		logic [`DM_DATA_WIDTH-1:0] e;
		logic [nameBits-1:0]       nm;
		logic [8*160-1:0]          line;
		while (!$feof(fd))
		begin
			count = $fscanf(fd, " %s", nm);
			if (count != 1)
				break;
			if ((nm[7:0] == "#") && (nm[nameBits-1:8] == '0))
				count = $fgets(line, fd); // skip comment text
			else
			begin
				count = $fscanf(fd, "%d %d %h %h %h %d", wr, op, a, w, e, flt);
				if (count != 6)
				begin
					$display("vector %0s in the input file is malformed", nm);
					failCount++;
					break;
				end
				vecName.push_back(nm);
				vecWr.push_back(wr[0]);
				vecOp.push_back(op[2:0]);
				vecAddr.push_back(a);
				vecWdata.push_back(w);
				vecExp.push_back(e);
				vecFault.push_back(flt[0]);
			end
		end
	endtask

	initial
	begin
		int                        fd;
		logic [31:0]               r;
		logic [31:0]               w;
		logic [9:0]                idx;
		logic [9:0]                idxList [$];
		logic [nameBits-1:0]       tname;
		rstN      = 1'b0;
		req       = '0;
		watchAddr = '0;
		pendValid = 1'b0;
		passCount = 0;
		failCount = 0;
		loaded    = 1'b0;
		lcgState  = 32'h8fef37cd;

		fd = $fopen("sim/dataMem_input.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the vector file sim/dataMem_input.txt");
			failCount++;
		end
		else
		begin
			loadVectors(fd);
			$fclose(fd);
			if (vecName.size() == 0)
			begin
				$display("no vectors were read from the vector file");
				failCount++;
			end
		end

		totalCycles = 5 + `DM_DEPTH_WORDS + vecName.size() + 2 * randWrites + 20;
		loaded      = 1'b1;

		if (failCount == 0)
		begin
			repeat (5) @(posedge clk);
			#1;
			rstN = 1'b1;
			$sformat(pendName, "reset_state");
			pendValid   = 1'b1;
			pendData    = '0;
			pendFault   = 1'b0;
			pendWatchOn = 1'b1;
			pendWatch   = '0;
			checkPending();

			clearMemory();

			for (int i = 0; i < vecName.size(); i++)
				issue(vecName[i], vecWr[i], vecOp[i], vecAddr[i], vecWdata[i], vecExp[i],
					vecFault[i], (vecOp[i] == 3'd2) && !vecFault[i], vecExp[i]);

			// upper half of memory, away from the file vectors
			for (int i = 0; i < randWrites; i++)
			begin
				r   = nextRandom();
				idx = {1'b1, r[24:16]};
				w   = nextRandom();
				$sformat(tname, "rand_wr_%0d", i);
				issue(tname, 1'b1, 3'd2, `DM_ADDR_WIDTH'({idx, 2'b00}), w, refMem[idx], 1'b0,
					1'b1, refMem[idx]);
				refMem[idx] = w;
				idxList.push_back(idx);
			end
			for (int i = 0; i < idxList.size(); i++)
			begin
				idx = idxList[i];
				$sformat(tname, "rand_rd_%0d", i);
				issue(tname, 1'b0, 3'd2, `DM_ADDR_WIDTH'({idx, 2'b00}), '0, refMem[idx], 1'b0,
					1'b1, refMem[idx]);
			end
			drainPipe();
		end

		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial
	begin
		wait (loaded);
		#(totalCycles * 10);
		$display("simulation timed out after %0d cycles", totalCycles);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- dataMem.f
+incdir+include
source/memAccessPkg.sv
source/laneBankPkg.sv
source/storeAligner.sv
source/byteLaneBank.sv
source/loadExtractor.sv
source/dataMem.sv
sim/clockGen.sv
sim/dataMemTb.sv

//--- run.sh
#!/bin/sh
# builds the dataMem testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	-f dataMem.f \
	--top-module dataMemTb \
	-Mdir obj_dir \
	-o dataMemSim

./obj_dir/dataMemSim | tee sim.log

if grep -q "^Regression passed$" sim.log; then
	echo "run.sh: simulation PASS"
	exit 0
else
	echo "run.sh: simulation FAIL, see sim.log"
	exit 1
fi

//--- sim/dataMem_input.txt
# name write op addr wdata expected fault
# op is func3 (0 lb/sb, 1 lh/sh, 2 lw/sw, 4 lbu, 5 lhu), addr and data in hex
word_store_0 1 2 00000010 deadbeef 00000000 0
word_load_0 0 2 00000010 00000000 deadbeef 0
word_store_1 1 2 00000014 12345678 00000000 0
word_load_1 0 2 00000014 00000000 12345678 0
byte_store_0 1 0 00000020 aabbcc81 00000000 0
byte_store_1 1 0 00000021 00000022 00000000 0
byte_store_2 1 0 00000022 000011f3 00000000 0
byte_store_3 1 0 00000023 00000044 00000000 0
byte_word_load 0 2 00000020 00000000 44f32281 0
lb_0 0 0 00000020 00000000 ffffff81 0
lbu_0 0 4 00000020 00000000 00000081 0
lb_1 0 0 00000021 00000000 00000022 0
lb_2 0 0 00000022 00000000 fffffff3 0
lbu_2 0 4 00000022 00000000 000000f3 0
lb_3 0 0 00000023 00000000 00000044 0
hw_pre 1 2 00000030 11223344 00000000 0
sh_0 1 1 00000030 5a5a8765 00003344 0
lh_0 0 1 00000030 00000000 ffff8765 0
lhu_0 0 5 00000030 00000000 00008765 0
hw_word_0 0 2 00000030 00000000 11228765 0
sh_2 1 1 00000032 0000c0de 00001122 0
lh_2 0 1 00000032 00000000 ffffc0de 0
lhu_2 0 5 00000032 00000000 0000c0de 0
hw_word_2 0 2 00000030 00000000 c0de8765 0
mis_pre 1 2 00000040 a5a5a5a5 00000000 0
mis_sh_1 1 1 00000041 0000ffff 00000000 1
mis_sh_3 1 1 00000043 0000ffff 00000000 1
mis_sw_2 1 2 00000042 ffffffff 00000000 1
mis_lh_1 0 1 00000041 00000000 00000000 1
mis_lhu_3 0 5 00000043 00000000 00000000 1
mis_lw_1 0 2 00000041 00000000 00000000 1
mis_check 0 2 00000040 00000000 a5a5a5a5 0
rw_pre 1 2 00000050 01010101 00000000 0
rw_store 1 2 00000050 cafef00d 01010101 0
rw_load 0 2 00000050 00000000 cafef00d 0
rw_sb 1 0 00000051 00000077 fffffff0 0
rw_lbu 0 4 00000051 00000000 00000077 0
unsigned_store 1 4 00000050 000000ff 0000000d 0
us_check 0 2 00000050 00000000 cafe770d 0
